// ==== hw/relay_config.svh ====
// Packet relay build constants included by the RTL packages, modules and the testbench
`ifndef RELAY_CONFIG_SVH
`define RELAY_CONFIG_SVH

// Payload bytes per packet as a power of two
`define PKT_LEN 16

// Packet buffer size in bytes giving four slots of PKT_LEN
`define PB_SIZE 64

// Cycles without an input byte before a partial packet is discarded
`define RX_IDLE_CYCLES 200

// Ethernet preamble bytes sent ahead of the start-of-frame delimiter
`define PREAMBLE_LEN 7

// Preamble and delimiter byte values
`define PREAMBLE_BYTE 8'h55
`define SFD_BYTE 8'hD5

`endif

// ==== hw/buffer_pkg.sv ====
// Types for packet buffer addressing and data imported by the buffer and queue logic
`include "relay_config.svh"

package buffer_pkg;

	// Byte address into the packet buffer
	typedef logic [$clog2(`PB_SIZE)-1:0] pb_addr_t;

	// Queue slot index that forms the upper part of a buffer address
	typedef logic [$clog2(`PB_SIZE / `PKT_LEN)-1:0] slot_t;

	// Byte position inside a packet that forms the lower part of a buffer address
	typedef logic [$clog2(`PKT_LEN)-1:0] byte_cnt_t;

	// One data byte
	typedef logic [7:0] byte_t;

endpackage

// ==== hw/rmii_pkg.sv ====
// Types for the RMII transmit side imported by the transmitter and the testbench
package rmii_pkg;

	// One RMII transmit symbol carrying two bits per clock
	typedef logic [1:0] dibit_t;

	// Transmitter frame phases
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_PAYLOAD
	} tx_state_t;

endpackage

// ==== hw/packet_buffer_ram.sv ====
// Byte-wide packet buffer with one write port and one registered read port
`timescale 1ns/1ps
`include "relay_config.svh"

module packet_buffer_ram
	import buffer_pkg::*;
(
	input  logic     clk,
	input  logic     we,
	input  pb_addr_t waddr,
	input  byte_t    wdata,
	input  logic     re,
	input  pb_addr_t raddr,
	output byte_t    rdata,
	output logic     rvalid
);

	byte_t mem [`PB_SIZE];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Read data and its strobe arrive together one cycle after re
	always_ff @(posedge clk) begin
		if (re)
			rdata <= mem[raddr];
		rvalid <= re;
	end

	// Reads only ever target bytes that a packet has already written
	a_rvalid_follows_re: assert property (@(posedge clk)
		re |=> rvalid && !$isunknown(rdata));

endmodule

// ==== hw/packet_queue_ctrl.sv ====
// Queue writer and scheduler that fills buffer slots from input bytes and launches frames
`timescale 1ns/1ps
`include "relay_config.svh"

module packet_queue_ctrl
	import buffer_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     rx_valid,
	input  byte_t    rx_byte,
	output logic     we,
	output pb_addr_t waddr,
	output byte_t    wdata,
	output logic     tx_start,
	output pb_addr_t tx_base,
	input  logic     tx_done
);

	localparam int IDLE_W = $clog2(`RX_IDLE_CYCLES);
	localparam byte_cnt_t LAST_BYTE = byte_cnt_t'(`PKT_LEN - 1);

	byte_cnt_t         byte_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	slot_t             tail;
	slot_t             head;
	slot_t             tail_next;
	logic              idle_expired;
	logic              busy;

	assign tail_next = tail + 1'b1;
	assign idle_expired = idle_cnt == IDLE_W'(`RX_IDLE_CYCLES - 1);

	// Bytes go straight into the tail slot
	assign we = rx_valid;
	assign waddr = {tail, byte_cnt};
	assign wdata = rx_byte;
	assign tx_base = {head, byte_cnt_t'(0)};

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt <= '0;
			idle_cnt <= '0;
			tail <= '0;
		end else if (rx_valid) begin
			idle_cnt <= '0;
			if (byte_cnt == LAST_BYTE) begin
				byte_cnt <= '0;
				// Full queue keeps the tail, so the packet is dropped
				if (tail_next != head)
					tail <= tail_next;
			end else begin
				byte_cnt <= byte_cnt + 1'b1;
			end
		end else if (idle_expired) begin
			// Sender went quiet and the partial packet is thrown away
			byte_cnt <= '0;
		end else begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// Oldest slot goes first with one frame in flight at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_start <= 1'b0;
			busy <= 1'b0;
			head <= '0;
		end else if (tx_start) begin
			tx_start <= 1'b0;
			busy <= 1'b1;
		end else if (busy && tx_done) begin
			busy <= 1'b0;
			head <= head + 1'b1;
		end else if (!busy && head != tail) begin
			tx_start <= 1'b1;
		end
	end

	a_head_behind_tail: assert property (@(posedge clk) disable iff (rst)
		busy && tx_done |-> head != tail);

	// Transmitter only reports the end of a frame that this block launched
	a_done_while_busy: assert property (@(posedge clk) disable iff (rst)
		tx_done |-> busy);

endmodule

// ==== hw/stream_from_memory.sv ====
// Prefetches one packet's bytes from the buffer into a holding register for the transmitter
`timescale 1ns/1ps
`include "relay_config.svh"

module stream_from_memory
	import buffer_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  pb_addr_t base,
	output logic     re,
	output pb_addr_t raddr,
	input  byte_t    rdata,
	input  logic     rvalid,
	output byte_t    byte_out,
	output logic     byte_ready,
	input  logic     byte_take
);

	localparam byte_cnt_t LAST_BYTE = byte_cnt_t'(`PKT_LEN - 1);

	slot_t     rd_slot;
	byte_cnt_t rd_cnt;
	logic      active;
	logic      rd_pend;

	// First read goes out with start, each later one with a take
	assign re = start || (byte_take && active);
	assign raddr = start ? base : {rd_slot, rd_cnt};

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			rd_pend <= 1'b0;
			byte_ready <= 1'b0;
		end else begin
			rd_pend <= re;
			if (start) begin
				active <= 1'b1;
				rd_slot <= base[$bits(pb_addr_t)-1 -: $bits(slot_t)];
				rd_cnt <= byte_cnt_t'(1);
				byte_ready <= 1'b0;
			end else begin
				if (byte_take && active) begin
					rd_cnt <= rd_cnt + 1'b1;
					// Last byte of the slot has been requested
					if (rd_cnt == LAST_BYTE)
						active <= 1'b0;
				end
				// Ignore a read that was in flight across reset
				if (rvalid && rd_pend)
					byte_ready <= 1'b1;
				else if (byte_take)
					byte_ready <= 1'b0;
			end
		end
	end

	// Holding register
	always_ff @(posedge clk) begin
		if (rvalid)
			byte_out <= rdata;
	end

	a_take_when_ready: assert property (@(posedge clk) disable iff (rst)
		byte_take |-> byte_ready ##1 !byte_ready);

endmodule

// ==== hw/rmii_tx.sv ====
// RMII transmitter sending preamble, delimiter and payload as dibits framed by tx_en
`timescale 1ns/1ps
`include "relay_config.svh"

module rmii_tx
	import buffer_pkg::*;
	import rmii_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  byte_t  byte_in,
	input  logic   byte_ready,
	output logic   byte_take,
	output logic   tx_en,
	output dibit_t tx_d,
	output logic   done
);

	localparam byte_cnt_t LAST_PREAMBLE = byte_cnt_t'(`PREAMBLE_LEN - 1);
	localparam byte_cnt_t LAST_PAYLOAD = byte_cnt_t'(`PKT_LEN - 1);

	tx_state_t  state;
	byte_t      shift;
	logic [1:0] dibit_cnt;
	byte_cnt_t  byte_pos;
	logic       last_dibit;

	assign last_dibit = dibit_cnt == 2'd3;

	// Next payload byte is loaded as the current byte finishes
	assign byte_take = last_dibit &&
		(state == TX_SFD || (state == TX_PAYLOAD && byte_pos != LAST_PAYLOAD));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= TX_IDLE;
			tx_en <= 1'b0;
			tx_d <= '0;
			done <= 1'b0;
			dibit_cnt <= '0;
			byte_pos <= '0;
		end else begin
			done <= 1'b0;
			tx_en <= state != TX_IDLE;
			tx_d <= (state != TX_IDLE) ? shift[1:0] : 2'b00;
			if (state != TX_IDLE) begin
				// LSB dibit first
				shift <= shift >> 2;
				dibit_cnt <= dibit_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					if (start) begin
						state <= TX_PREAMBLE;
						shift <= `PREAMBLE_BYTE;
						dibit_cnt <= '0;
						byte_pos <= '0;
					end
				end
				TX_PREAMBLE: begin
					if (last_dibit) begin
						if (byte_pos == LAST_PREAMBLE) begin
							state <= TX_SFD;
							shift <= `SFD_BYTE;
							byte_pos <= '0;
						end else begin
							shift <= `PREAMBLE_BYTE;
							byte_pos <= byte_pos + 1'b1;
						end
					end
				end
				TX_SFD: begin
					if (last_dibit) begin
						state <= TX_PAYLOAD;
						shift <= byte_in;
						byte_pos <= '0;
					end
				end
				TX_PAYLOAD: begin
					if (last_dibit) begin
						if (byte_pos == LAST_PAYLOAD) begin
							state <= TX_IDLE;
							done <= 1'b1;
						end else begin
							shift <= byte_in;
							byte_pos <= byte_pos + 1'b1;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	a_payload_ready: assert property (@(posedge clk) disable iff (rst)
		(state == TX_SFD || state == TX_PAYLOAD) && byte_take |-> byte_ready);

endmodule

// ==== hw/packet_relay_top.sv ====
// Packet relay top level joining the buffer, queue control, streamer and RMII transmitter
`timescale 1ns/1ps

module packet_relay_top
	import buffer_pkg::*;
	import rmii_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   rx_valid,
	input  byte_t  rx_byte,
	output logic   tx_en,
	output dibit_t tx_d
);

	// Buffer write side
	logic     ram_we;
	pb_addr_t ram_waddr;
	byte_t    ram_wdata;

	// Buffer read side
	logic     ram_re;
	pb_addr_t ram_raddr;
	byte_t    ram_rdata;
	logic     ram_rvalid;

	// Frame control
	logic     tx_start;
	pb_addr_t tx_base;
	logic     tx_done;

	// Payload hand-over to the transmitter
	byte_t    byte_out;
	logic     byte_ready;
	logic     byte_take;

	packet_buffer_ram ram_i (
		.clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.re(ram_re), .raddr(ram_raddr), .rdata(ram_rdata), .rvalid(ram_rvalid)
	);

	packet_queue_ctrl queue_i (
		.clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.tx_start(tx_start), .tx_base(tx_base), .tx_done(tx_done)
	);

	stream_from_memory stream_i (
		.clk(clk), .rst(rst), .start(tx_start), .base(tx_base),
		.re(ram_re), .raddr(ram_raddr), .rdata(ram_rdata), .rvalid(ram_rvalid),
		.byte_out(byte_out), .byte_ready(byte_ready), .byte_take(byte_take)
	);

	rmii_tx tx_i (
		.clk(clk), .rst(rst), .start(tx_start),
		.byte_in(byte_out), .byte_ready(byte_ready), .byte_take(byte_take),
		.tx_en(tx_en), .tx_d(tx_d), .done(tx_done)
	);

endmodule

// ==== verif/packet_relay_tb.sv ====
// Testbench for the packet relay that drives input bytes and checks every RMII frame against a model
`timescale 1ns/1ps
`include "relay_config.svh"

module packet_relay_tb
	import buffer_pkg::*;
	import rmii_pkg::*;
;

	localparam int FRAME_DIBITS = 4 * (`PREAMBLE_LEN + 1 + `PKT_LEN);
	localparam int FRAME_W = 2 * FRAME_DIBITS;
	localparam int PAYLOAD_W = 8 * `PKT_LEN;
	localparam int GAP_CYCLES = FRAME_DIBITS + 50;
	localparam int DRAIN_CYCLES = 3 * FRAME_DIBITS;
	localparam int IDLE_PAUSE = `RX_IDLE_CYCLES + 100;

	// Rough length of each test in cycles
	localparam int T1_CYCLES = `PKT_LEN + FRAME_DIBITS + 10 + DRAIN_CYCLES;
	localparam int T2_CYCLES = 3 * (`PKT_LEN + GAP_CYCLES) + FRAME_DIBITS + DRAIN_CYCLES;
	localparam int T3_CYCLES = 5 + IDLE_PAUSE + `PKT_LEN + FRAME_DIBITS + DRAIN_CYCLES;
	localparam int T4_CYCLES = 6 * `PKT_LEN + 3 * (FRAME_DIBITS + 4) + DRAIN_CYCLES;
	localparam int T5_CYCLES = 3 * `PKT_LEN + 2 * FRAME_DIBITS + DRAIN_CYCLES;
	localparam int CYCLE_LIMIT = 10 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES +
		T5_CYCLES + 3000;

	logic   clk;
	logic   rst;
	logic   rx_valid;
	byte_t  rx_byte;
	logic   tx_en;
	dibit_t tx_d;

	logic [31:0]          lcg_state = 32'hbe024ab8;
	logic [PAYLOAD_W-1:0] exp_q[$];
	dibit_t               got_q[$];
	int                   exp_idx = 0;
	int                   frames_seen = 0;
	int                   cuts_requested = 0;
	int                   cuts_seen = 0;
	int                   check_errors = 0;
	int                   monitor_errors = 0;
	int                   tests_run = 0;
	int                   tests_failed = 0;
	int                   cycle_cnt = 0;

	packet_relay_top dut_i (
		.clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.tx_en(tx_en), .tx_d(tx_d)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] seed);
		return seed * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic byte_t random_byte();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[23:16];
	endfunction

	// Expected frame with dibit i at bits [2i+1:2i] so each byte goes out LSB dibit first
	function automatic logic [FRAME_W-1:0] frame_dibits(input logic [PAYLOAD_W-1:0] payload);
		logic [FRAME_W-1:0] frame;
		byte_t b;
		int k;
		frame = '0;
		for (k = 0; k < `PREAMBLE_LEN + 1 + `PKT_LEN; k++) begin
			if (k < `PREAMBLE_LEN)
				b = `PREAMBLE_BYTE;
			else if (k == `PREAMBLE_LEN)
				b = `SFD_BYTE;
			else
				b = payload[8*(k-`PREAMBLE_LEN-1) +: 8];
			frame[8*k +: 8] = b;
		end
		return frame;
	endfunction

	function automatic int total_errors();
		return check_errors + monitor_errors;
	endfunction

	task automatic send_byte(input byte_t b);
		@(negedge clk);
		rx_valid = 1'b1;
		rx_byte = b;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			rx_valid = 1'b0;
		end
	endtask

	task automatic send_packet(output logic [PAYLOAD_W-1:0] payload);
		byte_t b;
		int p;
		payload = '0;
		for (p = 0; p < `PKT_LEN; p++) begin
			b = random_byte();
			payload[8*p +: 8] = b;
			send_byte(b);
		end
	endtask

	// Frame count only changes on falling edges, so poll it on rising ones
	task automatic wait_frames(input int target);
		while (frames_seen < target)
			@(posedge clk);
	endtask

	task automatic check_frame_count(input int expected);
		assert (frames_seen == expected) else begin
			$display("Wrong frame count: %0d frames seen, %0d expected", frames_seen, expected);
			check_errors++;
		end
		assert (exp_idx == exp_q.size()) else begin
			$display("Some expected frames were never transmitted");
			check_errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		int new_errors;
		new_errors = total_errors() - err_before;
		tests_run++;
		if (new_errors == 0) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, new_errors);
		end
	endtask

	task automatic check_frame();
		logic [FRAME_W-1:0] exp_frame;
		dibit_t exp_d;
		int mismatches;
		int i;
		mismatches = 0;
		if (cuts_seen < cuts_requested && got_q.size() != FRAME_DIBITS) begin
			// Frame ended by a reset, nothing to compare
			cuts_seen++;
		end else begin
			frames_seen++;
			assert (exp_idx < exp_q.size()) else begin
				$display("Unexpected frame of %0d dibits with no packet queued", got_q.size());
				monitor_errors++;
			end
			if (exp_idx < exp_q.size()) begin
				exp_frame = frame_dibits(exp_q[exp_idx]);
				exp_idx++;
				assert (got_q.size() == FRAME_DIBITS) else begin
					$display("Frame length is %0d dibits, expected %0d", got_q.size(),
						FRAME_DIBITS);
					monitor_errors++;
				end
				for (i = 0; i < FRAME_DIBITS && i < got_q.size(); i++) begin
					exp_d = exp_frame[2*i +: 2];
					if (mismatches == 0) begin
						assert (got_q[i] == exp_d) else begin
							$display("Fail tx_d index %0d expected %h got %h", i, exp_d,
								got_q[i]);
							monitor_errors++;
							mismatches++;
						end
					end
				end
			end
		end
	endtask

	// Monitor collects dibits while tx_en is high and checks on its falling edge
	always @(negedge clk) begin
		if (tx_en) begin
			got_q.push_back(tx_d);
		end else if (got_q.size() != 0) begin
			check_frame();
			got_q.delete();
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the expected frames never finished", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		logic [PAYLOAD_W-1:0] pkt;
		int err_before;
		int base;
		int n;
		rst = 1'b1;
		rx_valid = 1'b0;
		rx_byte = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// Single packet
		err_before = total_errors();
		base = frames_seen;
		assert (tx_en == 1'b0) else begin
			$display("Fail tx_en expected %h got %h", 1'b0, tx_en);
			check_errors++;
		end
		send_packet(pkt);
		exp_q.push_back(pkt);
		idle_cycles(1);
		wait_frames(base + 1);
		idle_cycles(DRAIN_CYCLES);
		check_frame_count(base + 1);
		finish_test("single_packet", err_before);

		// Ordering with gaps longer than a frame
		err_before = total_errors();
		base = frames_seen;
		for (n = 0; n < 3; n++) begin
			send_packet(pkt);
			exp_q.push_back(pkt);
			idle_cycles(GAP_CYCLES);
		end
		wait_frames(base + 3);
		idle_cycles(DRAIN_CYCLES);
		check_frame_count(base + 3);
		finish_test("ordering", err_before);

		// Partial packet discarded after the idle timeout
		err_before = total_errors();
		base = frames_seen;
		for (n = 0; n < 5; n++)
			send_byte(random_byte());
		idle_cycles(IDLE_PAUSE);
		send_packet(pkt);
		exp_q.push_back(pkt);
		idle_cycles(1);
		wait_frames(base + 1);
		idle_cycles(DRAIN_CYCLES);
		check_frame_count(base + 1);
		finish_test("idle_timeout", err_before);

		// Six packets back to back of which the queue keeps only the first three
		err_before = total_errors();
		base = frames_seen;
		for (n = 0; n < 6; n++) begin
			send_packet(pkt);
			if (n < 3)
				exp_q.push_back(pkt);
		end
		idle_cycles(1);
		wait_frames(base + 3);
		idle_cycles(DRAIN_CYCLES);
		check_frame_count(base + 3);
		finish_test("overflow", err_before);

		// Reset in the middle of a frame with a second packet waiting
		err_before = total_errors();
		base = frames_seen;
		send_packet(pkt);
		send_packet(pkt);
		idle_cycles(1);
		while (!tx_en)
			@(negedge clk);
		repeat (30) @(negedge clk);
		rst = 1'b1;
		cuts_requested++;
		@(negedge clk);
		assert (tx_en == 1'b0) else begin
			$display("Fail tx_en expected %h got %h", 1'b0, tx_en);
			check_errors++;
		end
		rst = 1'b0;
		idle_cycles(5);
		send_packet(pkt);
		exp_q.push_back(pkt);
		idle_cycles(1);
		wait_frames(base + 1);
		idle_cycles(DRAIN_CYCLES);
		check_frame_count(base + 1);
		finish_test("reset_mid_frame", err_before);

		$display("Tests run %0d, tests failed %0d, errors %0d, frames checked %0d",
			tests_run, tests_failed, total_errors(), frames_seen);
		if (total_errors() == 0 && tests_failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== packet_relay.f ====
+incdir+hw
hw/buffer_pkg.sv
hw/rmii_pkg.sv
hw/packet_buffer_ram.sv
hw/packet_queue_ctrl.sv
hw/stream_from_memory.sv
hw/rmii_tx.sv
hw/packet_relay_top.sv
verif/packet_relay_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := packet_relay_tb
RTL_TOP   := packet_relay_top
FILELIST  := packet_relay.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
